// File: source/softmax_pkg.sv
package softmax_pkg;

  localparam int num_lanes    = 4;
  localparam int elem_width   = 16;
  localparam int addr_width   = 5;
  localparam int buffer_depth = 32;
  localparam int diff_width   = 17;
  // 128 lanes of diff_width
  localparam int sum_width    = 24;

  typedef logic signed [elem_width-1:0] elem_t;
  typedef logic signed [diff_width-1:0] diff_t;
  typedef logic signed [sum_width-1:0]  sum_t;
  typedef logic [addr_width-1:0]        addr_t;

  // lane 0 in the low bits
  typedef elem_t [num_lanes-1:0] row_t;
  typedef diff_t [num_lanes-1:0] norm_row_t;

  typedef struct packed {
    addr_t base;
    addr_t limit;
  } addr_range_t;

  typedef struct packed {
    logic valid;
    logic first;
    logic last;
    row_t data;
  } row_beat_t;

  typedef struct packed {
    logic      valid;
    logic      first;
    logic      last;
    norm_row_t data;
  } norm_beat_t;

endpackage

// File: source/row_loader.sv
module row_loader (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     init,
  input  logic                     start,
  input  softmax_pkg::addr_t       start_addr,
  input  softmax_pkg::addr_t       end_addr,
  input  softmax_pkg::row_t        inp,
  output softmax_pkg::addr_t       addr,
  output softmax_pkg::addr_range_t range,
  output softmax_pkg::row_beat_t   load_beat,
  output softmax_pkg::addr_t       wr_addr
);

  logic busy;
  logic walking;
  softmax_pkg::addr_t last_addr;

  assign last_addr = softmax_pkg::addr_t'(range.limit - 1'b1);

  always_ff @(posedge clk) begin
    if (init) begin
      range.base  <= start_addr;
      range.limit <= end_addr;
    end
  end

  // one cycle from start to the first address, then one row per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      walking <= 1'b0;
      addr    <= '0;
    end else if (!busy) begin
      if (start) begin
        busy <= 1'b1;
      end
    end else if (!walking) begin
      addr    <= range.base;
      walking <= 1'b1;
    end else if (addr == last_addr) begin
      addr    <= '0;
      walking <= 1'b0;
      busy    <= 1'b0;
    end else begin
      addr <= addr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      load_beat.valid <= 1'b0;
    end else begin
      load_beat.valid <= walking;
    end
  end

  // row payload and where it came from
  always_ff @(posedge clk) begin
    load_beat.first <= (addr == range.base);
    load_beat.last  <= (addr == last_addr);
    load_beat.data  <= inp;
    wr_addr         <= addr;
  end

endmodule

// File: source/row_buffer.sv
module row_buffer (
  input  logic                   clk,
  input  softmax_pkg::row_beat_t load_beat,
  input  softmax_pkg::addr_t     wr_addr,
  input  softmax_pkg::addr_t     rd_addr,
  output softmax_pkg::row_t      rd_data
);

  softmax_pkg::row_t mem [softmax_pkg::buffer_depth];

  always_ff @(posedge clk) begin
    if (load_beat.valid) begin
      mem[wr_addr] <= load_beat.data;
    end
  end

  // registered read, one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: source/max_tracker.sv
module max_tracker (
  input  logic                   clk,
  input  logic                   reset,
  input  softmax_pkg::row_beat_t load_beat,
  output softmax_pkg::elem_t     max_value,
  output logic                   max_ready
);

  softmax_pkg::elem_t pair_max0;
  softmax_pkg::elem_t pair_max1;
  softmax_pkg::elem_t row_max;

  function automatic softmax_pkg::elem_t larger(
    input softmax_pkg::elem_t a,
    input softmax_pkg::elem_t b
  );
    return (a > b) ? a : b;
  endfunction

  // two-level compare tree over the lanes
  assign pair_max0 = larger(load_beat.data[0], load_beat.data[1]);
  assign pair_max1 = larger(load_beat.data[2], load_beat.data[3]);
  assign row_max   = larger(pair_max0, pair_max1);

  always_ff @(posedge clk) begin
    if (load_beat.valid) begin
      // a new pass restarts the maximum
      if (load_beat.first) begin
        max_value <= row_max;
      end else begin
        max_value <= larger(max_value, row_max);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      max_ready <= 1'b0;
    end else begin
      max_ready <= load_beat.valid && load_beat.last;
    end
  end

endmodule

// File: source/max_normalizer.sv
module max_normalizer (
  input  logic                     clk,
  input  logic                     reset,
  input  softmax_pkg::addr_range_t range,
  input  softmax_pkg::elem_t       max_value,
  input  logic                     max_ready,
  input  softmax_pkg::row_t        rd_data,
  output softmax_pkg::addr_t       rd_addr,
  output softmax_pkg::norm_beat_t  norm_beat
);

  logic rd_walk;
  logic rd_valid;
  logic rd_first;
  logic rd_last;
  softmax_pkg::addr_t last_addr;

  assign last_addr = softmax_pkg::addr_t'(range.limit - 1'b1);

  // second walk over the buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_walk <= 1'b0;
      rd_addr <= '0;
    end else if (max_ready) begin
      rd_walk <= 1'b1;
      rd_addr <= range.base;
    end else if (rd_walk) begin
      if (rd_addr == last_addr) begin
        rd_walk <= 1'b0;
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // flags follow the read latency of the buffer
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid        <= 1'b0;
      norm_beat.valid <= 1'b0;
    end else begin
      rd_valid        <= rd_walk;
      norm_beat.valid <= rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    rd_first        <= (rd_addr == range.base);
    rd_last         <= (rd_addr == last_addr);
    norm_beat.first <= rd_first;
    norm_beat.last  <= rd_last;
    for (int i = 0; i < softmax_pkg::num_lanes; i++) begin
      norm_beat.data[i] <= softmax_pkg::diff_t'($signed(rd_data[i]))
                         - softmax_pkg::diff_t'($signed(max_value));
    end
  end

endmodule

// File: source/sum_tree.sv
module sum_tree (
  input  logic                    clk,
  input  logic                    reset,
  input  softmax_pkg::norm_beat_t norm_beat,
  output softmax_pkg::sum_t       sum,
  output logic                    done
);

  softmax_pkg::sum_t pair_sum0;
  softmax_pkg::sum_t pair_sum1;
  logic s1_valid;
  logic s1_first;
  logic s1_last;

  // stage 1, lane pairs
  always_ff @(posedge clk) begin
    pair_sum0 <= softmax_pkg::sum_t'($signed(norm_beat.data[0]))
               + softmax_pkg::sum_t'($signed(norm_beat.data[1]));
    pair_sum1 <= softmax_pkg::sum_t'($signed(norm_beat.data[2]))
               + softmax_pkg::sum_t'($signed(norm_beat.data[3]));
    s1_first  <= norm_beat.first;
    s1_last   <= norm_beat.last;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      done     <= 1'b0;
    end else begin
      s1_valid <= norm_beat.valid;
      done     <= s1_valid && s1_last;
    end
  end

  // stage 2, final add into the accumulator
  always_ff @(posedge clk) begin
    if (reset) begin
      sum <= '0;
    end else if (s1_valid) begin
      if (s1_first) begin
        sum <= pair_sum0 + pair_sum1;
      end else begin
        sum <= sum + pair_sum0 + pair_sum1;
      end
    end
  end

endmodule

// File: source/softmax_top.sv
module softmax_top (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      init,
  input  logic                      start,
  input  softmax_pkg::addr_t        start_addr,
  input  softmax_pkg::addr_t        end_addr,
  input  softmax_pkg::row_t         inp,
  output softmax_pkg::addr_t        addr,
  output softmax_pkg::norm_row_t    out_row,
  output logic                      out_valid,
  output softmax_pkg::sum_t         sum,
  output logic                      done
);

  softmax_pkg::row_beat_t   load_beat;
  softmax_pkg::addr_range_t range;
  softmax_pkg::addr_t       wr_addr;
  softmax_pkg::addr_t       rd_addr;
  softmax_pkg::row_t        rd_data;
  softmax_pkg::elem_t       max_value;
  logic                     max_ready;
  softmax_pkg::norm_beat_t  norm_beat;

  assign out_row   = norm_beat.data;
  assign out_valid = norm_beat.valid;

  // load pass
  row_loader loader0 (.clk, .reset, .init, .start, .start_addr, .end_addr, .inp,
                      .addr, .range, .load_beat, .wr_addr);

  row_buffer buffer0 (.clk, .load_beat, .wr_addr, .rd_addr, .rd_data);

  max_tracker tracker0 (.clk, .reset, .load_beat, .max_value, .max_ready);

  // normalize pass
  max_normalizer normalizer0 (.clk, .reset, .range, .max_value, .max_ready, .rd_data,
                              .rd_addr, .norm_beat);

  sum_tree adder0 (.clk, .reset, .norm_beat, .sum, .done);

endmodule

// File: bench/softmax_assertions.sv
module softmax_assertions (
  input logic clk,
  input logic reset,
  input logic start,
  input logic out_valid,
  input logic done
);

  logic idle;
  int failures = 0;

  // set once a run has finished, cleared by the next start
  always_ff @(posedge clk) begin
    if (reset || start) begin
      idle <= 1'b0;
    end else if (done) begin
      idle <= 1'b1;
    end
  end

  done_single_cycle: assert property (
    @(posedge clk) disable iff (reset) done |=> !done
  ) else begin
    $error("done high for two cycles in a row");
    failures++;
  end

  quiet_after_reset: assert property (
    @(posedge clk) reset |=> (!out_valid && !done)
  ) else begin
    $error("out_valid or done high right after reset");
    failures++;
  end

  no_rows_after_done: assert property (
    @(posedge clk) disable iff (reset) idle |-> !out_valid
  ) else begin
    $error("out_valid after done and before a new start");
    failures++;
  end

endmodule

bind softmax_top softmax_assertions checks0 (.clk, .reset, .start, .out_valid, .done);

// File: bench/softmax_tb.sv
module softmax_tb;

  logic clk = 1'b0;
  logic reset;
  logic init;
  logic start;
  softmax_pkg::addr_t start_addr;
  softmax_pkg::addr_t end_addr;
  softmax_pkg::row_t inp;
  softmax_pkg::addr_t addr;
  softmax_pkg::norm_row_t out_row;
  logic out_valid;
  softmax_pkg::sum_t sum;
  logic done;

  softmax_pkg::row_t ext_mem [softmax_pkg::buffer_depth];
  softmax_pkg::row_t golden_rows [256];
  logic [8*16-1:0] case_name [16];
  int case_base [16];
  int case_limit [16];
  int case_row [16];
  int case_max [16];
  int case_sum [16];
  int num_cases = 0;
  int cycle = 0;
  int start_cycle;
  int watchdog_limit = 0;
  int value_errors = 0;
  int other_errors = 0;

  softmax_top dut0 (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // external storage answers the address shown after each rising edge
  always @(negedge clk) begin
    inp <= ext_mem[addr];
  end

  task automatic load_golden();
    int fd;
    int num_rows;
    int a0, a1, a2, a3;
    logic [8*80-1:0] line;
    logic [8*8-1:0] kind;
    logic [8*16-1:0] name_buf;
    num_rows = 0;
    fd = $fopen("bench/softmax_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/softmax_golden.txt");
      other_errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = '0;
      kind = '0;
      if ($fgets(line, fd) == 0) break;
      if ($sscanf(line, "%s", kind) != 1) continue;
      if (kind == "case") begin
        void'($sscanf(line, "%s %s %d %d", kind, name_buf, a0, a1));
        case_name[num_cases] = name_buf;
        case_base[num_cases] = a0;
        case_limit[num_cases] = a1;
        case_row[num_cases] = num_rows;
        num_cases++;
      end else if (kind == "row") begin
        void'($sscanf(line, "%s %d %d %d %d", kind, a0, a1, a2, a3));
        golden_rows[num_rows][0] = softmax_pkg::elem_t'(a0);
        golden_rows[num_rows][1] = softmax_pkg::elem_t'(a1);
        golden_rows[num_rows][2] = softmax_pkg::elem_t'(a2);
        golden_rows[num_rows][3] = softmax_pkg::elem_t'(a3);
        num_rows++;
      end else if (kind == "expect") begin
        void'($sscanf(line, "%s %d %d", kind, a0, a1));
        case_max[num_cases-1] = a0;
        case_sum[num_cases-1] = a1;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input int c);
    int n;
    int rows_seen;
    int k;
    int expected;
    int actual;
    logic got_done;
    n = case_limit[c] - case_base[c];
    // random fill so stale rows never line up with the golden data
    for (int a = 0; a < softmax_pkg::buffer_depth; a++) begin
      ext_mem[a] = {$urandom, $urandom};
    end
    for (int r = 0; r < n; r++) begin
      ext_mem[case_base[c] + r] = golden_rows[case_row[c] + r];
    end
    @(negedge clk);
    init = 1'b1;
    start_addr = softmax_pkg::addr_t'(case_base[c]);
    end_addr = softmax_pkg::addr_t'(case_limit[c]);
    @(negedge clk);
    init = 1'b0;
    start = 1'b1;
    start_cycle = cycle + 1;
    rows_seen = 0;
    got_done = 1'b0;
    while (!got_done) begin
      @(negedge clk);
      start = 1'b0;
      k = cycle - start_cycle;
      if (k >= 1 && k <= n && (addr < case_base[c] || addr >= case_limit[c])) begin
        $display("%0s: load address %0d is outside the range", case_name[c], addr);
        other_errors++;
      end
      if (out_valid && rows_seen >= n) begin
        $display("%0s: extra output row after %0d rows", case_name[c], n);
        other_errors++;
      end else if (out_valid) begin
        for (int l = 0; l < softmax_pkg::num_lanes; l++) begin
          expected = int'(golden_rows[case_row[c] + rows_seen][l]) - case_max[c];
          actual = int'(out_row[l]);
          if (actual != expected) begin
            $display("[FAIL] %0s row %0d lane %0d: expected %0d, actual %0d",
                     case_name[c], rows_seen, l, expected, actual);
            value_errors++;
          end
        end
        rows_seen++;
      end
      if (done) begin
        got_done = 1'b1;
        if (int'(sum) != case_sum[c]) begin
          $display("[FAIL] %0s sum: expected %0d, actual %0d", case_name[c], case_sum[c],
                   int'(sum));
          value_errors++;
        end
        if (k != 2 * n + 6) begin
          $display("[FAIL] %0s done latency: expected %0d, actual %0d", case_name[c],
                   2 * n + 6, k);
          value_errors++;
        end
      end
    end
    if (rows_seen != n) begin
      $display("%0s: %0d output rows missing", case_name[c], n - rows_seen);
      other_errors++;
    end
    repeat (2) begin
      @(negedge clk);
      if (out_valid || done) begin
        $display("%0s: output activity after done", case_name[c]);
        other_errors++;
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    init = 1'b0;
    start = 1'b0;
    start_addr = '0;
    end_addr = '0;
    inp = '0;
    void'($urandom(32'h07162816));
    load_golden();
    watchdog_limit = 16;
    for (int c = 0; c < num_cases; c++) begin
      watchdog_limit += 2 * (case_limit[c] - case_base[c]) + 20;
    end
    repeat (16) @(negedge clk);
    reset = 1'b0;
    for (int c = 0; c < num_cases; c++) begin
      run_case(c);
    end
    other_errors += dut0.checks0.failures;
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0 && num_cases > 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (watchdog_limit != 0);
    repeat (watchdog_limit) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", watchdog_limit);
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: list.f
source/softmax_pkg.sv
source/row_loader.sv
source/row_buffer.sv
source/max_tracker.sv
source/max_normalizer.sv
source/sum_tree.sv
source/softmax_top.sv
bench/softmax_assertions.sv
bench/softmax_tb.sv

// File: Bender.yml
package:
  name: softmax

sources:
  - source/softmax_pkg.sv
  - source/row_loader.sv
  - source/row_buffer.sv
  - source/max_tracker.sv
  - source/max_normalizer.sv
  - source/sum_tree.sv
  - source/softmax_top.sv
  - target: test
    files:
      - bench/softmax_assertions.sv
      - bench/softmax_tb.sv

// File: bench/softmax_golden.txt
# case: name start_addr end_addr | row: lanes 0 to 3, signed decimal
# expect: golden maximum and golden sum of all (lane - maximum)
case multi_row 3 9
row 100 -20 35 7
row 12 250 -300 64
row -5 0 18 1000
row 400 -1000 999 3
row 0 0 0 0
row -77 512 128 -256
expect 1000 -22130
case single_row 20 21
row 5 -3 42 17
expect 42 -107
case all_negative 0 4
row -500 -40 -1200 -32768
row -7 -3 -90 -100
row -32000 -2 -15000 -64
row -11 -9 -300 -5
expect -2 -82067
case max_lane0 25 28
row 32767 100 -32768 0
row 200 300 400 500
row -1 -2 -3 -4
expect 32767 -391715
